// File: step_motor_pkg.sv
`default_nettype none

package step_motor_pkg;

	localparam int SPEED_W  = 16;
	localparam int STEP_W   = 16;
	localparam int TABLE_AW = 9;
	localparam int MS_W     = 3;
	localparam int APB_AW   = 13;

	typedef logic [SPEED_W-1:0]  speed_t;
	typedef logic [STEP_W-1:0]   step_t;
	typedef logic [TABLE_AW-1:0] table_addr_t;
	typedef logic [MS_W-1:0]     ms_t;
	typedef logic [APB_AW-1:0]   apb_addr_t;
	typedef logic [31:0]         apb_data_t;

	localparam apb_addr_t REG_CTRL        = 13'h0000;
	localparam apb_addr_t REG_SPEED       = 13'h0004;
	localparam apb_addr_t REG_STEPS       = 13'h0008;
	localparam apb_addr_t REG_STROKE      = 13'h000C;
	localparam apb_addr_t REG_RAMP        = 13'h0010;
	localparam apb_addr_t REG_PRESCALE    = 13'h0014;
	localparam apb_addr_t REG_STATUS      = 13'h0018;
	localparam apb_addr_t REG_POSITION    = 13'h001C;
	localparam apb_addr_t ACCE_TABLE_BASE = 13'h0800;
	localparam apb_addr_t DEAC_TABLE_BASE = 13'h1000;

	typedef enum logic [1:0] {
		IDLE    = 2'b00,
		PREPARE = 2'b10,
		RUNNING = 2'b11
	} motor_state_e;

endpackage

`default_nettype wire

// File: step_motor_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module step_motor_apb_regs #(
	parameter int SPEED_W  = step_motor_pkg::SPEED_W,
	parameter int STEP_W   = step_motor_pkg::STEP_W,
	parameter int TABLE_AW = step_motor_pkg::TABLE_AW,
	parameter int MS_W     = step_motor_pkg::MS_W
) (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      i_psel,
	input  logic                      i_penable,
	input  logic                      i_pwrite,
	input  step_motor_pkg::apb_addr_t i_paddr,
	input  step_motor_pkg::apb_data_t i_pwdata,
	output step_motor_pkg::apb_data_t o_prdata,
	output logic                      o_pready,
	output logic                      o_pslverr,
	output logic                      o_start,
	output logic                      o_stop,
	output logic                      o_dir,
	output logic [MS_W-1:0]           o_ms,
	output logic                      o_xen,
	output logic                      o_xrst,
	output logic [SPEED_W-1:0]        o_speed,
	output logic [STEP_W-1:0]         o_steps,
	output logic [STEP_W-1:0]         o_stroke,
	output logic [TABLE_AW-1:0]       o_acce_len,
	output logic [TABLE_AW-1:0]       o_deac_len,
	output logic [SPEED_W-1:0]        o_prescale,
	output logic                      o_acce_we,
	output logic                      o_deac_we,
	output logic [TABLE_AW-1:0]       o_table_addr,
	output logic [SPEED_W-1:0]        o_table_data,
	input  logic                      i_busy,
	input  logic [SPEED_W-1:0]        i_cur_speed,
	input  logic                      i_zpsign,
	input  logic                      i_tpsign,
	input  logic [STEP_W-1:0]         i_position
);

	logic access;
	logic wr_en;
	logic reg_hit;
	logic sel_acce;
	logic sel_deac;

	assign access = i_psel && i_penable;
	assign wr_en  = access && i_pwrite;

	// each table window is 2 KB, matched on the upper address bits
	assign sel_acce = (i_paddr[12:11] == step_motor_pkg::ACCE_TABLE_BASE[12:11]);
	assign sel_deac = (i_paddr[12:11] == step_motor_pkg::DEAC_TABLE_BASE[12:11]);

	assign o_acce_we    = wr_en && sel_acce;
	assign o_deac_we    = wr_en && sel_deac;
	assign o_table_addr = i_paddr[TABLE_AW+1:2];
	assign o_table_data = i_pwdata[SPEED_W-1:0];

	assign o_pready  = 1'b1;
	assign o_pslverr = access && !(reg_hit || sel_acce || sel_deac);

	always_comb begin
		reg_hit  = 1'b1;
		o_prdata = '0;
		case (i_paddr)
		step_motor_pkg::REG_CTRL: begin
			o_prdata[2]         = o_dir;
			o_prdata[4 +: MS_W] = o_ms;
			o_prdata[8]         = o_xen;
			o_prdata[9]         = o_xrst;
		end
		step_motor_pkg::REG_SPEED:    o_prdata[SPEED_W-1:0] = o_speed;
		step_motor_pkg::REG_STEPS:    o_prdata[STEP_W-1:0] = o_steps;
		step_motor_pkg::REG_STROKE:   o_prdata[STEP_W-1:0] = o_stroke;
		step_motor_pkg::REG_RAMP: begin
			o_prdata[0 +: TABLE_AW]  = o_acce_len;
			o_prdata[16 +: TABLE_AW] = o_deac_len;
		end
		step_motor_pkg::REG_PRESCALE: o_prdata[SPEED_W-1:0] = o_prescale;
		step_motor_pkg::REG_STATUS: begin
			o_prdata[0]            = i_busy;
			o_prdata[1]            = i_zpsign;
			o_prdata[2]            = i_tpsign;
			o_prdata[16 +: SPEED_W] = i_cur_speed;
		end
		step_motor_pkg::REG_POSITION: o_prdata[STEP_W-1:0] = i_position;
		default: reg_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_start    <= 1'b0;
			o_stop     <= 1'b0;
			o_dir      <= 1'b0;
			o_ms       <= '0;
			o_xen      <= 1'b0;
			o_xrst     <= 1'b0;
			o_speed    <= '0;
			o_steps    <= '0;
			o_stroke   <= '0;
			o_acce_len <= '0;
			o_deac_len <= '0;
			o_prescale <= '0;
		end else begin
			// start and stop bits self-clear
			o_start <= 1'b0;
			o_stop  <= 1'b0;
			if (wr_en) begin
				case (i_paddr)
				step_motor_pkg::REG_CTRL: begin
					o_start <= i_pwdata[0];
					o_stop  <= i_pwdata[1];
					o_dir   <= i_pwdata[2];
					o_ms    <= i_pwdata[4 +: MS_W];
					o_xen   <= i_pwdata[8];
					o_xrst  <= i_pwdata[9];
				end
				step_motor_pkg::REG_SPEED:    o_speed <= i_pwdata[SPEED_W-1:0];
				step_motor_pkg::REG_STEPS:    o_steps <= i_pwdata[STEP_W-1:0];
				step_motor_pkg::REG_STROKE:   o_stroke <= i_pwdata[STEP_W-1:0];
				step_motor_pkg::REG_RAMP: begin
					o_acce_len <= i_pwdata[0 +: TABLE_AW];
					o_deac_len <= i_pwdata[16 +: TABLE_AW];
				end
				step_motor_pkg::REG_PRESCALE: o_prescale <= i_pwdata[SPEED_W-1:0];
				default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: step_clk_en_gen.sv
`timescale 1ns/1ps
`default_nettype none

module step_clk_en_gen #(
	parameter int CNT_W = step_motor_pkg::SPEED_W
) (
	input  logic             clk,
	input  logic             resetn,
	input  logic [CNT_W-1:0] i_prescale,
	output logic             o_tick
);

	logic [CNT_W-1:0] cnt;

	// one tick per reload, every prescale+1 clocks
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == '0) begin
			cnt    <= i_prescale;
			o_tick <= 1'b1;
		end else begin
			cnt    <= cnt - 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: speed_ramp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module speed_ramp_ram #(
	parameter int AW = step_motor_pkg::TABLE_AW,
	parameter int DW = step_motor_pkg::SPEED_W
) (
	input  logic          clk,
	input  logic          i_we,
	input  logic [AW-1:0] i_waddr,
	input  logic [DW-1:0] i_wdata,
	input  logic          i_re,
	input  logic [AW-1:0] i_raddr,
	output logic [DW-1:0] o_rdata
);

	logic [DW-1:0] mem [2**AW];
	logic [AW-1:0] raddr_q;

	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// address register then output register
	always_ff @(posedge clk) begin
		if (i_re) begin
			raddr_q <= i_raddr;
		end
		o_rdata <= mem[raddr_q];
	end

endmodule

`default_nettype wire

// File: step_position_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module step_position_tracker #(
	parameter int STEP_W = step_motor_pkg::STEP_W
) (
	input  logic              clk,
	input  logic              resetn,
	input  logic              i_running,
	input  logic              i_dir,
	input  logic              i_step,
	input  logic              i_zpd,
	input  logic [STEP_W-1:0] i_stroke,
	output logic              o_zpsign,
	output logic              o_tpsign,
	output logic [STEP_W-1:0] o_position
);

	logic step_d1;
	logic step_fall;
	logic at_stroke;

	assign step_fall = step_d1 && !i_step;
	assign at_stroke = (o_position == i_stroke);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			step_d1  <= 1'b0;
			o_zpsign <= 1'b0;
			o_tpsign <= 1'b0;
		end else begin
			step_d1  <= i_step;
			o_tpsign <= at_stroke;
			// latch holds until the motor moves forward off the sensor
			if (i_zpd) begin
				o_zpsign <= 1'b1;
			end else if (i_running && !i_dir) begin
				o_zpsign <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn || o_zpsign) begin
			o_position <= STEP_W'(1);
		end else if (step_fall) begin
			if (!i_dir) begin
				if (!at_stroke) begin
					o_position <= o_position + 1'b1;
				end
			end else if (o_position > STEP_W'(1)) begin
				o_position <= o_position - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: step_motor_core.sv
`timescale 1ns/1ps
`default_nettype none

module step_motor_core #(
	parameter int SPEED_W       = step_motor_pkg::SPEED_W,
	parameter int STEP_W        = step_motor_pkg::STEP_W,
	parameter int TABLE_AW      = step_motor_pkg::TABLE_AW,
	parameter int MS_W          = step_motor_pkg::MS_W,
	parameter int REVERSE_DELAY = 4
) (
	input  logic                clk,
	input  logic                resetn,
	input  logic                i_tick,
	input  logic                i_start,
	input  logic                i_stop,
	input  logic                i_dir,
	input  logic [MS_W-1:0]     i_ms,
	input  logic [SPEED_W-1:0]  i_speed,
	input  logic [STEP_W-1:0]   i_steps,
	input  logic [TABLE_AW-1:0] i_acce_len,
	input  logic [TABLE_AW-1:0] i_deac_len,
	output logic                o_acce_re,
	output logic [TABLE_AW-1:0] o_acce_addr,
	input  logic [SPEED_W-1:0]  i_acce_data,
	output logic                o_deac_re,
	output logic [TABLE_AW-1:0] o_deac_addr,
	input  logic [SPEED_W-1:0]  i_deac_data,
	input  logic                i_zpsign,
	input  logic                i_tpsign,
	output logic                o_step,
	output logic                o_dir,
	output logic [MS_W-1:0]     o_ms,
	output logic                o_busy,
	output logic [SPEED_W-1:0]  o_cur_speed
);

	localparam int REV_W = $clog2(REVERSE_DELAY);

	step_motor_pkg::motor_state_e state;

	logic [SPEED_W-1:0] speed_max;
	logic [SPEED_W-1:0] speed_var;
	logic [SPEED_W-1:0] speed_cnt;
	logic [STEP_W-1:0]  step_cnt;
	logic [STEP_W-1:0]  step_remain;
	logic [REV_W-1:0]   rev_cnt;
	logic [4:0]         rd_pipe;
	logic               rd_en;
	logic               start_pend;
	logic               stop_pend;
	logic               step_done;
	logic               acce_ing;
	logic               deac_ing;
	logic               is_idle;
	logic               is_running;
	logic               should_start;
	logic               half_done;
	logic               step_edge;
	logic               should_stop;

	assign is_idle      = (state == step_motor_pkg::IDLE);
	assign is_running   = (state == step_motor_pkg::RUNNING);
	assign should_start = i_tick && start_pend && is_idle;
	assign half_done    = (speed_cnt == '0);
	// a step completes when the high half runs out
	assign step_edge    = half_done && o_step;
	assign should_stop  = (step_done && half_done) || (i_tpsign && !o_dir) || (i_zpsign && o_dir);
	assign o_busy       = !is_idle;

	// requests wait for the next tick
	always_ff @(posedge clk) begin
		if (!resetn) begin
			start_pend <= 1'b0;
			stop_pend  <= 1'b0;
		end else begin
			if (start_pend) begin
				if (i_tick) start_pend <= 1'b0;
			end else if (i_start && is_idle) begin
				start_pend <= 1'b1;
			end
			if (stop_pend) begin
				if (i_tick) stop_pend <= 1'b0;
			end else if (i_stop && !is_idle) begin
				stop_pend <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_dir <= 1'b0;
			o_ms  <= '0;
		end else if (should_start) begin
			o_dir <= i_dir;
			o_ms  <= i_ms;
		end
	end

	always_ff @(posedge clk) begin
		if (should_start) begin
			speed_max <= i_speed;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state   <= step_motor_pkg::IDLE;
			rev_cnt <= '0;
		end else if (i_tick) begin
			case (state)
			step_motor_pkg::IDLE: begin
				rev_cnt <= '0;
				if (start_pend) begin
					state <= (o_dir == i_dir) ? step_motor_pkg::RUNNING : step_motor_pkg::PREPARE;
				end
			end
			step_motor_pkg::PREPARE: begin
				rev_cnt <= rev_cnt + 1'b1;
				if (stop_pend) begin
					state <= step_motor_pkg::IDLE;
				end else if (rev_cnt == REV_W'(REVERSE_DELAY - 2)) begin
					state <= step_motor_pkg::RUNNING;
				end
			end
			default: begin
				if (stop_pend || should_stop) begin
					state <= step_motor_pkg::IDLE;
				end
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			step_cnt    <= '0;
			step_remain <= '0;
			step_done   <= 1'b0;
			speed_cnt   <= '0;
			o_step      <= 1'b0;
		end else if (i_tick) begin
			if (!is_running) begin
				step_done <= 1'b0;
				o_step    <= 1'b0;
				if (is_idle) speed_cnt <= '0;
				if (should_start) begin
					step_cnt    <= '0;
					step_remain <= i_steps - 1'b1;
				end
			end else begin
				speed_cnt <= half_done ? o_cur_speed : speed_cnt - 1'b1;
				if (half_done && !step_done) o_step <= !o_step;
				if (step_edge) begin
					step_cnt    <= step_cnt + 1'b1;
					step_remain <= step_remain - 1'b1;
					if (step_remain == '0) step_done <= 1'b1;
				end
			end
		end
	end

	// table lookup on start and after every completed step
	always_ff @(posedge clk) begin
		if (!resetn) begin
			rd_en   <= 1'b0;
			rd_pipe <= '0;
		end else begin
			rd_en   <= !rd_en && i_tick && ((is_idle && start_pend) || (is_running && step_edge));
			rd_pipe <= {rd_pipe[3:0], rd_en};
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			acce_ing <= (step_cnt < STEP_W'(i_acce_len));
			deac_ing <= (step_remain < STEP_W'(i_deac_len));
		end
		if (rd_pipe[0]) begin
			o_acce_addr <= acce_ing ? TABLE_AW'(step_cnt) : i_acce_len;
			o_deac_addr <= deac_ing ? TABLE_AW'(step_remain) : i_deac_len;
		end
		if (rd_pipe[3]) begin
			speed_var <= (i_acce_data > i_deac_data) ? i_acce_data : i_deac_data;
		end
	end

	assign o_acce_re = rd_pipe[1];
	assign o_deac_re = rd_pipe[1];

	// slowest of the two ramps and the commanded speed
	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_cur_speed <= '0;
		end else if (rd_pipe[4]) begin
			o_cur_speed <= (speed_var > speed_max) ? speed_var : speed_max;
		end
	end

endmodule

`default_nettype wire

// File: step_motor_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module step_motor_ctrl #(
	parameter int SPEED_W       = $bits(step_motor_pkg::speed_t),
	parameter int STEP_W        = $bits(step_motor_pkg::step_t),
	parameter int TABLE_AW      = $bits(step_motor_pkg::table_addr_t),
	parameter int MS_W          = $bits(step_motor_pkg::ms_t),
	parameter int REVERSE_DELAY = 4
) (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      i_psel,
	input  logic                      i_penable,
	input  logic                      i_pwrite,
	input  step_motor_pkg::apb_addr_t i_paddr,
	input  step_motor_pkg::apb_data_t i_pwdata,
	output step_motor_pkg::apb_data_t o_prdata,
	output logic                      o_pready,
	output logic                      o_pslverr,
	input  logic                      i_zpd,
	output logic                      o_step,
	output logic                      o_dir,
	output logic [MS_W-1:0]           o_ms,
	output logic                      o_xen,
	output logic                      o_xrst,
	output logic                      o_zpsign,
	output logic                      o_tpsign
);

	logic                tick, start, stop, cmd_dir, busy;
	logic                acce_we, deac_we, acce_re, deac_re;
	logic [MS_W-1:0]     cmd_ms;
	logic [SPEED_W-1:0]  speed, prescale, cur_speed, table_data, acce_data, deac_data;
	logic [STEP_W-1:0]   steps, stroke, position;
	logic [TABLE_AW-1:0] acce_len, deac_len, table_addr, acce_addr, deac_addr;

	step_motor_apb_regs #(
		.SPEED_W(SPEED_W), .STEP_W(STEP_W), .TABLE_AW(TABLE_AW), .MS_W(MS_W)
	) u_regs (
		.clk(clk), .resetn(resetn),
		.i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
		.i_paddr(i_paddr), .i_pwdata(i_pwdata), .o_prdata(o_prdata),
		.o_pready(o_pready), .o_pslverr(o_pslverr),
		.o_start(start), .o_stop(stop), .o_dir(cmd_dir), .o_ms(cmd_ms),
		.o_xen(o_xen), .o_xrst(o_xrst), .o_speed(speed), .o_steps(steps),
		.o_stroke(stroke), .o_acce_len(acce_len), .o_deac_len(deac_len),
		.o_prescale(prescale), .o_acce_we(acce_we), .o_deac_we(deac_we),
		.o_table_addr(table_addr), .o_table_data(table_data),
		.i_busy(busy), .i_cur_speed(cur_speed), .i_zpsign(o_zpsign),
		.i_tpsign(o_tpsign), .i_position(position)
	);

	step_clk_en_gen #(.CNT_W(SPEED_W)) u_clk_en (
		.clk(clk), .resetn(resetn), .i_prescale(prescale), .o_tick(tick)
	);

	speed_ramp_ram #(.AW(TABLE_AW), .DW(SPEED_W)) acce_ram (
		.clk(clk), .i_we(acce_we), .i_waddr(table_addr), .i_wdata(table_data),
		.i_re(acce_re), .i_raddr(acce_addr), .o_rdata(acce_data)
	);

	speed_ramp_ram #(.AW(TABLE_AW), .DW(SPEED_W)) deac_ram (
		.clk(clk), .i_we(deac_we), .i_waddr(table_addr), .i_wdata(table_data),
		.i_re(deac_re), .i_raddr(deac_addr), .o_rdata(deac_data)
	);

	step_position_tracker #(.STEP_W(STEP_W)) u_tracker (
		.clk(clk), .resetn(resetn), .i_running(busy), .i_dir(o_dir), .i_step(o_step),
		.i_zpd(i_zpd), .i_stroke(stroke), .o_zpsign(o_zpsign), .o_tpsign(o_tpsign),
		.o_position(position)
	);

	step_motor_core #(
		.SPEED_W(SPEED_W), .STEP_W(STEP_W), .TABLE_AW(TABLE_AW), .MS_W(MS_W),
		.REVERSE_DELAY(REVERSE_DELAY)
	) u_core (
		.clk(clk), .resetn(resetn), .i_tick(tick), .i_start(start), .i_stop(stop),
		.i_dir(cmd_dir), .i_ms(cmd_ms), .i_speed(speed), .i_steps(steps),
		.i_acce_len(acce_len), .i_deac_len(deac_len),
		.o_acce_re(acce_re), .o_acce_addr(acce_addr), .i_acce_data(acce_data),
		.o_deac_re(deac_re), .o_deac_addr(deac_addr), .i_deac_data(deac_data),
		.i_zpsign(o_zpsign), .i_tpsign(o_tpsign), .o_step(o_step), .o_dir(o_dir),
		.o_ms(o_ms), .o_busy(busy), .o_cur_speed(cur_speed)
	);

endmodule

`default_nettype wire

// File: step_motor_checker.sv
`timescale 1ns/1ps
`default_nettype none

module step_motor_checker (
	input  logic                clk,
	input  logic                resetn,
	input  logic                i_step,
	input  logic                i_dir,
	input  step_motor_pkg::ms_t i_ms,
	input  logic [15:0]         i_prescale
);

	int                  err_count = 0;
	int                  edge_count = 0;
	int                  half_idx;
	int                  clk_since;
	int                  lead_min;
	int                  exp_half [0:1023];
	logic                armed = 1'b0;
	logic                halves_on;
	logic                exp_dir;
	logic                step_q;
	step_motor_pkg::ms_t exp_ms;
	string               test_name;

	task automatic check_value(input string name, input string what, input int exp,
			input int act);
		if (exp !== act) begin
			err_count++;
			$display("ERR %s: %s expected 'h%0h actual 'h%0h", name, what, exp, act);
		end
	endtask

	task automatic arm_move(input string name, input logic dir, input int ms,
			input logic halves, input int lead);
		test_name  = name;
		exp_dir    = dir;
		exp_ms     = step_motor_pkg::ms_t'(ms);
		halves_on  = halves;
		lead_min   = lead;
		edge_count = 0;
		half_idx   = 0;
		clk_since  = 0;
		armed      = 1'b1;
	endtask

	task automatic close_move(input logic exact, input int exp_edges);
		armed = 1'b0;
		if (exact) begin
			check_value(test_name, "step count", exp_edges, edge_count);
		end else if (edge_count >= exp_edges) begin
			err_count++;
			$display("%s: %0d steps seen, the move should have ended before %0d",
				test_name, edge_count, exp_edges);
		end
	endtask

	// toggles are seen one clock late, spacing stays exact
	always @(posedge clk) begin
		int period;
		period = i_prescale + 1;
		step_q <= i_step;
		if (armed && resetn) begin
			clk_since = clk_since + 1;
			if (i_step !== step_q) begin
				if (half_idx == 0 && clk_since < lead_min * period) begin
					err_count++;
					$display("%s: first step came %0d clocks after start, inside the reverse delay",
						test_name, clk_since);
				end
				if (half_idx > 0 && halves_on) begin
					check_value(test_name, "half-period ticks", exp_half[(half_idx - 1) / 2],
						clk_since / period);
				end
				if (i_step) begin
					edge_count++;
					check_value(test_name, "o_dir", exp_dir, i_dir);
					check_value(test_name, "o_ms", exp_ms, i_ms);
				end
				half_idx++;
				clk_since = 0;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_step_motor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_step_motor;

	localparam int PRESCALE      = 9;
	localparam int REVERSE_DELAY = 4;
	localparam int TIMEOUT       = 100000;

	logic                      clk;
	logic                      resetn;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	step_motor_pkg::apb_addr_t paddr;
	step_motor_pkg::apb_data_t pwdata;
	step_motor_pkg::apb_data_t prdata;
	logic                      pready;
	logic                      pslverr;
	logic                      zpd;
	logic                      step;
	logic                      dir;
	step_motor_pkg::ms_t       ms;
	logic                      xen;
	logic                      xrst;
	logic                      zpsign;
	logic                      tpsign;
	logic [31:0]               lcg_state = 32'h8df43de0;
	logic                      step_seen = 1'b0;
	int                        model_pos = 1;
	int                        exp_count;
	int                        acce_tab [0:511];
	int                        deac_tab [0:511];
	int                        exp_half [0:1023];

	step_motor_ctrl #(.REVERSE_DELAY(REVERSE_DELAY)) DUT (
		.clk(clk), .resetn(resetn), .i_psel(psel), .i_penable(penable),
		.i_pwrite(pwrite), .i_paddr(paddr), .i_pwdata(pwdata), .o_prdata(prdata),
		.o_pready(pready), .o_pslverr(pslverr), .i_zpd(zpd), .o_step(step),
		.o_dir(dir), .o_ms(ms), .o_xen(xen), .o_xrst(xrst), .o_zpsign(zpsign),
		.o_tpsign(tpsign)
	);

	step_motor_checker chk (
		.clk(clk), .resetn(resetn), .i_step(step), .i_dir(dir), .i_ms(ms),
		.i_prescale(16'(PRESCALE))
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// zero sensor sits at position 1 and below
	always @(posedge clk) begin
		if (step_seen && !step) begin
			model_pos = dir ? model_pos - 1 : model_pos + 1;
		end
		step_seen = step;
		#10;
		zpd = (model_pos <= 1);
	end

	function automatic int lcg_range(input int lo, input int hi);
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lo + int'(lcg_state[30:16]) % (hi - lo + 1);
	endfunction

	// slowest of the clamped ramp entries and the speed, plus one tick
	function automatic int ref_move(input int steps, input int speed, input int alen,
			input int dlen);
		int k;
		int a;
		int d;
		int v;
		for (k = 0; k < steps; k++) begin
			a = (k < alen) ? k : alen;
			d = (steps - 1 - k < dlen) ? steps - 1 - k : dlen;
			v = (acce_tab[a] > deac_tab[d]) ? acce_tab[a] : deac_tab[d];
			if (speed > v) v = speed;
			exp_half[k] = v + 1;
		end
		return steps;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$finish;
	endtask

	task automatic apb_xfer(input logic wr, input step_motor_pkg::apb_addr_t addr,
			input step_motor_pkg::apb_data_t wdata, output step_motor_pkg::apb_data_t rdata,
			output logic err);
		int n;
		n = 0;
		@(posedge clk);
		#10;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#10;
		penable = 1'b1;
		@(negedge clk);
		while (!pready) begin
			n++;
			if (n > 16) abort_run("APB slave never raised pready");
			@(negedge clk);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		#10;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic reg_write(input step_motor_pkg::apb_addr_t addr,
			input step_motor_pkg::apb_data_t data);
		step_motor_pkg::apb_data_t rd;
		logic err;
		apb_xfer(1'b1, addr, data, rd, err);
		chk.check_value("apb", "pslverr on write", 0, err);
	endtask

	task automatic read_reg(input step_motor_pkg::apb_addr_t addr,
			output step_motor_pkg::apb_data_t data);
		logic err;
		apb_xfer(1'b0, addr, '0, data, err);
		chk.check_value("apb", "pslverr on read", 0, err);
	endtask

	task automatic load_tables(input int flat);
		int i;
		for (i = 0; i < 16; i++) begin
			acce_tab[i] = (flat < 0) ? lcg_range(0, 19) : flat;
			deac_tab[i] = (flat < 0) ? lcg_range(0, 19) : flat;
			reg_write(step_motor_pkg::ACCE_TABLE_BASE + 13'(i * 4), 32'(acce_tab[i]));
			reg_write(step_motor_pkg::DEAC_TABLE_BASE + 13'(i * 4), 32'(deac_tab[i]));
		end
	endtask

	task automatic start_move(input string name, input int mdir, input int mms,
			input int steps, input int speed, input int alen, input int dlen,
			input logic halves, input int lead);
		int k;
		reg_write(step_motor_pkg::REG_SPEED, 32'(speed));
		reg_write(step_motor_pkg::REG_STEPS, 32'(steps));
		reg_write(step_motor_pkg::REG_RAMP, 32'((dlen << 16) | alen));
		exp_count = ref_move(steps, speed, alen, dlen);
		for (k = 0; k < steps; k++) begin
			chk.exp_half[k] = exp_half[k];
		end
		// start, direction, microstep, driver enable
		reg_write(step_motor_pkg::REG_CTRL, 32'(1 + mdir * 4 + mms * 16 + 256));
		chk.arm_move(name, mdir[0], mms, halves, lead);
	endtask

	task automatic wait_move_done(input string name);
		step_motor_pkg::apb_data_t rd;
		int n;
		n  = 0;
		rd = '0;
		while (rd[0] == 1'b0) begin
			n++;
			if (n > 200) abort_run({name, ": busy never rose after the start"});
			read_reg(step_motor_pkg::REG_STATUS, rd);
		end
		n = 0;
		while (rd[0] == 1'b1) begin
			n++;
			if (n > TIMEOUT) abort_run({name, ": busy never fell"});
			read_reg(step_motor_pkg::REG_STATUS, rd);
		end
		n = 0;
		while (step !== 1'b0) begin
			n++;
			if (n > TIMEOUT) abort_run({name, ": step output stayed high after the move"});
			@(negedge clk);
		end
	endtask

	initial begin
		step_motor_pkg::apb_data_t rd;
		logic err;
		int steps;
		int spd;
		int alen;
		int dlen;
		int pos0;
		int n;
		resetn  = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		zpd     = 1'b1;
		repeat (16) @(posedge clk);
		#10;
		resetn = 1'b1;

		// idle after reset with the sensor at zero
		@(negedge clk);
		chk.check_value("reset", "o_step", 0, step);
		chk.check_value("reset", "o_xen", 0, xen);
		chk.check_value("reset", "o_xrst", 0, xrst);
		read_reg(step_motor_pkg::REG_STATUS, rd);
		chk.check_value("reset", "STATUS", 'h2, rd);
		chk.check_value("reset", "o_zpsign", 1, zpsign);
		chk.check_value("reset", "o_tpsign", 0, tpsign);
		apb_xfer(1'b0, 13'h0020, '0, rd, err);
		chk.check_value("reset", "pslverr on unmapped", 1, err);
		reg_write(step_motor_pkg::REG_PRESCALE, PRESCALE);

		load_tables(3);
		start_move("flat", 0, 3, 16, 7, 5, 5, 1'b1, 0);
		wait_move_done("flat");
		chk.close_move(1'b1, exp_count);
		chk.check_value("flat", "o_xen", 1, xen);

		load_tables(-1);
		steps = lcg_range(12, 27);
		spd   = lcg_range(1, 6);
		alen  = lcg_range(3, 10);
		dlen  = lcg_range(3, 10);
		start_move("ramp", 0, 1, steps, spd, alen, dlen, 1'b1, 0);
		wait_move_done("ramp");
		chk.close_move(1'b1, exp_count);

		start_move("reverse", 1, 6, 8, 2, alen, dlen, 1'b1, REVERSE_DELAY - 1);
		wait_move_done("reverse");
		chk.close_move(1'b1, exp_count);

		start_move("stop", 0, 5, 30, 4, alen, dlen, 1'b0, 0);
		n = 0;
		while (chk.edge_count < 4) begin
			n++;
			if (n > TIMEOUT) abort_run("stop: steps never started");
			@(negedge clk);
		end
		reg_write(step_motor_pkg::REG_CTRL, 32'(2 + 5 * 16 + 256));
		wait_move_done("stop");
		chk.close_move(1'b0, 30);

		// run into the end of the stroke, then back onto the sensor
		read_reg(step_motor_pkg::REG_POSITION, rd);
		pos0 = int'(rd);
		reg_write(step_motor_pkg::REG_STROKE, 32'(pos0 + 10));
		start_move("stroke", 0, 2, 40, 1, alen, dlen, 1'b0, 0);
		wait_move_done("stroke");
		chk.close_move(1'b0, 40);
		read_reg(step_motor_pkg::REG_POSITION, rd);
		chk.check_value("stroke", "POSITION", pos0 + 10, rd);
		read_reg(step_motor_pkg::REG_STATUS, rd);
		chk.check_value("stroke", "terminal sign", 1, rd[2]);
		chk.check_value("stroke", "o_tpsign", 1, tpsign);
		chk.check_value("stroke", "o_zpsign", 0, zpsign);
		steps = pos0 + 30;
		start_move("zero", 1, 2, steps, 1, alen, dlen, 1'b0, REVERSE_DELAY - 1);
		wait_move_done("zero");
		chk.close_move(1'b0, steps);
		read_reg(step_motor_pkg::REG_POSITION, rd);
		chk.check_value("zero", "POSITION", 1, rd);
		read_reg(step_motor_pkg::REG_STATUS, rd);
		chk.check_value("zero", "zero sign", 1, rd[1]);
		chk.check_value("zero", "o_zpsign", 1, zpsign);
		chk.check_value("zero", "o_tpsign", 0, tpsign);

		$display("errors: %0d", chk.err_count);
		if (chk.err_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: step_motor_ctrl.f
step_motor_pkg.sv
step_motor_apb_regs.sv
step_clk_en_gen.sv
speed_ramp_ram.sv
step_position_tracker.sv
step_motor_core.sv
step_motor_ctrl.sv
step_motor_checker.sv
tb_step_motor.sv

// File: Bender.yml
package:
  name: step_motor_ctrl

sources:
  - step_motor_pkg.sv
  - step_motor_apb_regs.sv
  - step_clk_en_gen.sv
  - speed_ramp_ram.sv
  - step_position_tracker.sv
  - step_motor_core.sv
  - step_motor_ctrl.sv
  - target: simulation
    files:
      - step_motor_checker.sv
      - tb_step_motor.sv
